/* hdl/priv_defines.svh */
// Fixed configuration for an RV32 machine-mode unit; the PMA regions must not overlap
`ifndef PRIV_DEFINES_SVH
`define PRIV_DEFINES_SVH

// Data and address width
`define PRIV_XLEN 32

// Trap vector after reset, direct mode
`define PRIV_MTVEC_RESET 32'h0000_0100

// RAM region, fetch, load and store allowed
`define PMA_MEM_BASE 32'h0000_0000
`define PMA_MEM_TOP 32'h0000_ffff

// IO region, load and store only
`define PMA_IO_BASE 32'h8000_0000
`define PMA_IO_TOP 32'h8000_0fff

`endif

/* hdl/priv_pkg.sv */
// Machine-mode types only; interrupt causes reuse exception code values, so they are typed constants
`default_nettype none

package priv_pkg;

    // Implemented machine CSRs, standard encodings
    typedef enum logic [11:0] {
        CSR_MSTATUS  = 12'h300,
        CSR_MIE      = 12'h304,
        CSR_MTVEC    = 12'h305,
        CSR_MSCRATCH = 12'h340,
        CSR_MEPC     = 12'h341,
        CSR_MCAUSE   = 12'h342,
        CSR_MTVAL    = 12'h343,
        CSR_MIP      = 12'h344,
        CSR_MINSTRET = 12'hb02
    } csr_addr_e;

    // Exception codes, mcause without the interrupt bit
    typedef enum logic [30:0] {
        INSN_MISALIGNED  = 31'd0,
        INSN_FAULT       = 31'd1,
        ILLEGAL_INSN     = 31'd2,
        BREAKPOINT       = 31'd3,
        LOAD_MISALIGNED  = 31'd4,
        LOAD_FAULT       = 31'd5,
        STORE_MISALIGNED = 31'd6,
        STORE_FAULT      = 31'd7,
        ENV_CALL_M       = 31'd11
    } cause_e;

    // Machine interrupt codes
    localparam cause_e SOFT_INT_M  = cause_e'(31'd3);
    localparam cause_e TIMER_INT_M = cause_e'(31'd7);
    localparam cause_e EXT_INT_M   = cause_e'(31'd11);

    typedef enum logic [1:0] {
        MTVEC_DIRECT   = 2'd0,
        MTVEC_VECTORED = 2'd1
    } mtvec_mode_e;

endpackage

`default_nettype wire

/* hdl/priv_csr.sv */
// Machine CSRs only; minstret is 32 bits with no minstreth, and a trapping instruction's CSR write is dropped
`timescale 1ns/100ps
`include "priv_defines.svh"
`default_nettype none

module priv_csr (
    input  logic                   CLK,
    input  logic                   rst_n,
    input  logic [11:0]            csr_addr,
    input  logic                   swap,
    input  logic                   set,
    input  logic                   clr,
    input  logic [`PRIV_XLEN-1:0]  wdata,
    input  logic                   valid_write,
    input  logic                   wb_enable,
    input  logic                   instr,
    input  logic                   timer_int,
    input  logic                   soft_int,
    input  logic                   ext_int,
    input  logic                   timer_int_clear,
    input  logic                   soft_int_clear,
    input  logic                   ext_int_clear,
    input  logic                   trap_take,
    input  logic                   intr,
    input  priv_pkg::cause_e       trap_cause,
    input  logic                   mret_take,
    input  logic [`PRIV_XLEN-1:0]  epc,
    input  logic [`PRIV_XLEN-1:0]  badaddr,
    output logic [`PRIV_XLEN-1:0]  rdata,
    output logic                   invalid_csr,
    output logic [`PRIV_XLEN-1:0]  mtvec,
    output logic [`PRIV_XLEN-1:0]  mepc,
    output logic [`PRIV_XLEN-1:0]  mie,
    output logic [`PRIV_XLEN-1:0]  mip,
    output logic                   mstatus_mie
);

    // Only MSIE, MTIE and MEIE exist
    localparam logic [`PRIV_XLEN-1:0] MIE_MASK = 32'h0000_0888;

    logic                  mpie_q;
    logic [`PRIV_XLEN-1:0] mtvec_q;
    logic [`PRIV_XLEN-1:0] mscratch_q;
    logic [`PRIV_XLEN-1:0] mcause_q;
    logic [`PRIV_XLEN-1:0] mtval_q;
    logic [`PRIV_XLEN-1:0] minstret_q;
    logic [`PRIV_XLEN-1:0] mstatus_rd;
    logic [`PRIV_XLEN-1:0] csr_new;
    logic                  csr_wr;

    // MPP is hardwired to machine mode
    always_comb begin
        mstatus_rd        = '0;
        mstatus_rd[3]     = mstatus_mie;
        mstatus_rd[7]     = mpie_q;
        mstatus_rd[12:11] = 2'b11;
    end

    always_comb begin
        rdata       = '0;
        invalid_csr = 1'b0;
        case (csr_addr)
            priv_pkg::CSR_MSTATUS:  rdata = mstatus_rd;
            priv_pkg::CSR_MIE:      rdata = mie;
            priv_pkg::CSR_MTVEC:    rdata = mtvec_q;
            priv_pkg::CSR_MSCRATCH: rdata = mscratch_q;
            priv_pkg::CSR_MEPC:     rdata = mepc;
            priv_pkg::CSR_MCAUSE:   rdata = mcause_q;
            priv_pkg::CSR_MTVAL:    rdata = mtval_q;
            priv_pkg::CSR_MIP:      rdata = mip;
            priv_pkg::CSR_MINSTRET: rdata = minstret_q;
            default:                invalid_csr = 1'b1;
        endcase
    end

    // Read-modify-write value, swap has priority
    always_comb begin
        if (swap) begin
            csr_new = wdata;
        end else if (set) begin
            csr_new = rdata | wdata;
        end else begin
            csr_new = rdata & ~wdata;
        end
    end

    assign csr_wr = valid_write & (swap | set | clr) & ~invalid_csr & ~trap_take;

    // mstatus: trap entry and mret beat software writes
    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            mstatus_mie <= 1'b0;
            mpie_q      <= 1'b0;
        end else if (trap_take) begin
            mpie_q      <= mstatus_mie;
            mstatus_mie <= 1'b0;
        end else if (mret_take) begin
            mstatus_mie <= mpie_q;
            mpie_q      <= 1'b1;
        end else if (csr_wr && csr_addr == priv_pkg::CSR_MSTATUS) begin
            mstatus_mie <= csr_new[3];
            mpie_q      <= csr_new[7];
        end
    end

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            mie     <= '0;
            mtvec_q <= `PRIV_MTVEC_RESET;
        end else if (csr_wr) begin
            if (csr_addr == priv_pkg::CSR_MIE) begin
                mie <= csr_new & MIE_MASK;
            end
            // Mode bit 1 reads as zero, only direct and vectored exist
            if (csr_addr == priv_pkg::CSR_MTVEC) begin
                mtvec_q <= {csr_new[`PRIV_XLEN-1:2], 1'b0, csr_new[0]};
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (trap_take) begin
            mepc    <= epc;
            mtval_q <= intr ? '0 : badaddr;
        end else if (csr_wr) begin
            if (csr_addr == priv_pkg::CSR_MEPC) mepc <= csr_new;
            if (csr_addr == priv_pkg::CSR_MTVAL) mtval_q <= csr_new;
            if (csr_addr == priv_pkg::CSR_MSCRATCH) mscratch_q <= csr_new;
        end
    end

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            mcause_q <= '0;
        end else if (trap_take) begin
            mcause_q <= {intr, trap_cause};
        end else if (csr_wr && csr_addr == priv_pkg::CSR_MCAUSE) begin
            mcause_q <= csr_new;
        end
    end

    // Pending bits follow the lines, clear wins
    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            mip <= '0;
        end else begin
            if (soft_int_clear) mip[3] <= 1'b0;
            else if (soft_int) mip[3] <= 1'b1;
            if (timer_int_clear) mip[7] <= 1'b0;
            else if (timer_int) mip[7] <= 1'b1;
            if (ext_int_clear) mip[11] <= 1'b0;
            else if (ext_int) mip[11] <= 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            minstret_q <= '0;
        end else if (csr_wr && csr_addr == priv_pkg::CSR_MINSTRET) begin
            minstret_q <= csr_new;
        end else if (wb_enable && instr) begin
            minstret_q <= minstret_q + 1'b1;
        end
    end

    assign mtvec = mtvec_q;

endmodule

`default_nettype wire

/* hdl/priv_trap_handler.sv */
// Machine interrupts are taken only on a clear pipeline; exception ranking is fixed
`timescale 1ns/100ps
`include "priv_defines.svh"
`default_nettype none

module priv_trap_handler (
    input  logic                  fault_insn,
    input  logic                  mal_insn,
    input  logic                  illegal_insn,
    input  logic                  fault_l,
    input  logic                  mal_l,
    input  logic                  fault_s,
    input  logic                  mal_s,
    input  logic                  breakpoint,
    input  logic                  env_m,
    input  logic                  ret,
    input  logic                  pipe_clear,
    input  logic                  i_fault,
    input  logic                  l_fault,
    input  logic                  s_fault,
    input  logic [`PRIV_XLEN-1:0] mie,
    input  logic [`PRIV_XLEN-1:0] mip,
    input  logic                  mstatus_mie,
    output logic                  trap_take,
    output logic                  intr,
    output priv_pkg::cause_e      trap_cause,
    output logic                  mret_take
);

    logic             insn_fault;
    logic             load_fault;
    logic             store_fault;
    logic             exception;
    logic             soft_pend;
    logic             timer_pend;
    logic             ext_pend;
    priv_pkg::cause_e ex_cause;
    priv_pkg::cause_e int_cause;

    // PMA faults merge with the pipeline's own access faults
    assign insn_fault  = fault_insn | i_fault;
    assign load_fault  = fault_l | l_fault;
    assign store_fault = fault_s | s_fault;

    assign exception = insn_fault | mal_insn | illegal_insn | breakpoint | env_m
                     | mal_s | store_fault | mal_l | load_fault;

    always_comb begin
        if (insn_fault)        ex_cause = priv_pkg::INSN_FAULT;
        else if (mal_insn)     ex_cause = priv_pkg::INSN_MISALIGNED;
        else if (illegal_insn) ex_cause = priv_pkg::ILLEGAL_INSN;
        else if (breakpoint)   ex_cause = priv_pkg::BREAKPOINT;
        else if (env_m)        ex_cause = priv_pkg::ENV_CALL_M;
        else if (mal_s)        ex_cause = priv_pkg::STORE_MISALIGNED;
        else if (store_fault)  ex_cause = priv_pkg::STORE_FAULT;
        else if (mal_l)        ex_cause = priv_pkg::LOAD_MISALIGNED;
        else                   ex_cause = priv_pkg::LOAD_FAULT;
    end

    // Enabled and pending
    assign soft_pend  = mie[3] & mip[3];
    assign timer_pend = mie[7] & mip[7];
    assign ext_pend   = mie[11] & mip[11];

    always_comb begin
        if (ext_pend)       int_cause = priv_pkg::EXT_INT_M;
        else if (soft_pend) int_cause = priv_pkg::SOFT_INT_M;
        else                int_cause = priv_pkg::TIMER_INT_M;
    end

    assign intr = ~exception & pipe_clear & mstatus_mie & (ext_pend | soft_pend | timer_pend);

    assign trap_take  = exception | intr;
    assign trap_cause = exception ? ex_cause : int_cause;
    // A trap in the same cycle squashes the return
    assign mret_take  = ret & ~trap_take;

endmodule

`default_nettype wire

/* hdl/priv_pipe_control.sv */
// Vectored mode offsets interrupts only; exceptions always go to the mtvec base
`timescale 1ns/100ps
`include "priv_defines.svh"
`default_nettype none

module priv_pipe_control (
    input  logic                  trap_take,
    input  logic                  intr,
    input  priv_pkg::cause_e      trap_cause,
    input  logic                  mret_take,
    input  logic [`PRIV_XLEN-1:0] mtvec,
    input  logic [`PRIV_XLEN-1:0] mepc,
    output logic                  insert_pc,
    output logic [`PRIV_XLEN-1:0] priv_pc
);

    logic [`PRIV_XLEN-1:0] base;
    priv_pkg::mtvec_mode_e mode;

    assign base = {mtvec[`PRIV_XLEN-1:2], 2'b00};
    assign mode = priv_pkg::mtvec_mode_e'(mtvec[1:0]);

    assign insert_pc = trap_take | mret_take;

    always_comb begin
        if (mret_take) begin
            priv_pc = mepc;
        end else if (intr && mode == priv_pkg::MTVEC_VECTORED) begin
            // base + 4 * cause
            priv_pc = base + {trap_cause[`PRIV_XLEN-3:0], 2'b00};
        end else begin
            priv_pc = base;
        end
    end

endmodule

`default_nettype wire

/* hdl/priv_pma.sv */
// Fixed memory map from the defines header; fetch is checked every cycle, data only on ren or wen
`timescale 1ns/100ps
`include "priv_defines.svh"
`default_nettype none

module priv_pma (
    input  logic [`PRIV_XLEN-1:0] iaddr,
    input  logic [`PRIV_XLEN-1:0] daddr,
    input  logic                  ren,
    input  logic                  wen,
    output logic                  i_fault,
    output logic                  l_fault,
    output logic                  s_fault
);

    logic i_in_mem;
    logic d_in_mem;
    logic d_in_io;
    logic d_ok;

    assign i_in_mem = (iaddr >= `PMA_MEM_BASE) && (iaddr <= `PMA_MEM_TOP);
    assign d_in_mem = (daddr >= `PMA_MEM_BASE) && (daddr <= `PMA_MEM_TOP);
    assign d_in_io  = (daddr >= `PMA_IO_BASE) && (daddr <= `PMA_IO_TOP);
    assign d_ok     = d_in_mem | d_in_io;

    // IO is not executable
    assign i_fault = ~i_in_mem;
    assign l_fault = ren & ~d_ok;
    assign s_fault = wen & ~d_ok;

endmodule

`default_nettype wire

/* hdl/priv_block.sv */
// Machine mode only; pipeline inputs are single-cycle levels with no back-pressure
`timescale 1ns/100ps
`include "priv_defines.svh"
`default_nettype none

module priv_block (
    input  logic                  CLK,
    input  logic                  rst_n,
    input  logic [11:0]           csr_addr,
    input  logic                  swap,
    input  logic                  set,
    input  logic                  clr,
    input  logic [`PRIV_XLEN-1:0] wdata,
    input  logic                  valid_write,
    input  logic                  wb_enable,
    input  logic                  instr,
    input  logic                  fault_insn,
    input  logic                  mal_insn,
    input  logic                  illegal_insn,
    input  logic                  fault_l,
    input  logic                  mal_l,
    input  logic                  fault_s,
    input  logic                  mal_s,
    input  logic                  breakpoint,
    input  logic                  env_m,
    input  logic                  ret,
    input  logic [`PRIV_XLEN-1:0] epc,
    input  logic [`PRIV_XLEN-1:0] badaddr,
    input  logic                  pipe_clear,
    input  logic [`PRIV_XLEN-1:0] iaddr,
    input  logic [`PRIV_XLEN-1:0] daddr,
    input  logic                  ren,
    input  logic                  wen,
    input  logic                  timer_int,
    input  logic                  soft_int,
    input  logic                  ext_int,
    input  logic                  timer_int_clear,
    input  logic                  soft_int_clear,
    input  logic                  ext_int_clear,
    output logic [`PRIV_XLEN-1:0] rdata,
    output logic                  invalid_csr,
    output logic                  insert_pc,
    output logic [`PRIV_XLEN-1:0] priv_pc,
    output logic                  intr
);

    logic                  i_fault;
    logic                  l_fault;
    logic                  s_fault;
    logic                  trap_take;
    logic                  mret_take;
    logic                  mstatus_mie;
    priv_pkg::cause_e      trap_cause;
    logic [`PRIV_XLEN-1:0] mtvec;
    logic [`PRIV_XLEN-1:0] mepc;
    logic [`PRIV_XLEN-1:0] mie;
    logic [`PRIV_XLEN-1:0] mip;

    priv_csr i_priv_csr (
        .CLK(CLK), .rst_n(rst_n),
        .csr_addr(csr_addr), .swap(swap), .set(set), .clr(clr),
        .wdata(wdata), .valid_write(valid_write),
        .wb_enable(wb_enable), .instr(instr),
        .timer_int(timer_int), .soft_int(soft_int), .ext_int(ext_int),
        .timer_int_clear(timer_int_clear), .soft_int_clear(soft_int_clear),
        .ext_int_clear(ext_int_clear),
        .trap_take(trap_take), .intr(intr), .trap_cause(trap_cause),
        .mret_take(mret_take), .epc(epc), .badaddr(badaddr),
        .rdata(rdata), .invalid_csr(invalid_csr), .mtvec(mtvec), .mepc(mepc),
        .mie(mie), .mip(mip), .mstatus_mie(mstatus_mie)
    );

    priv_trap_handler i_priv_trap_handler (
        .fault_insn(fault_insn), .mal_insn(mal_insn), .illegal_insn(illegal_insn),
        .fault_l(fault_l), .mal_l(mal_l), .fault_s(fault_s), .mal_s(mal_s),
        .breakpoint(breakpoint), .env_m(env_m), .ret(ret), .pipe_clear(pipe_clear),
        .i_fault(i_fault), .l_fault(l_fault), .s_fault(s_fault),
        .mie(mie), .mip(mip), .mstatus_mie(mstatus_mie),
        .trap_take(trap_take), .intr(intr), .trap_cause(trap_cause),
        .mret_take(mret_take)
    );

    priv_pipe_control i_priv_pipe_control (
        .trap_take(trap_take), .intr(intr), .trap_cause(trap_cause),
        .mret_take(mret_take), .mtvec(mtvec), .mepc(mepc),
        .insert_pc(insert_pc), .priv_pc(priv_pc)
    );

    priv_pma i_priv_pma (
        .iaddr(iaddr), .daddr(daddr), .ren(ren), .wen(wen),
        .i_fault(i_fault), .l_fault(l_fault), .s_fault(s_fault)
    );

endmodule

`default_nettype wire

/* verification/priv_asserts.sv */
// Shadow model of the machine CSRs; mepc, mscratch and mtval are compared only once known
`timescale 1ns/100ps
`include "priv_defines.svh"
`default_nettype none

module priv_asserts (
    input logic                  CLK,
    input logic                  rst_n,
    input logic [11:0]           csr_addr,
    input logic                  swap, set, clr, valid_write, wb_enable, instr,
    input logic [`PRIV_XLEN-1:0] wdata, epc, badaddr, iaddr, daddr, rdata, priv_pc,
    input logic                  fault_insn, mal_insn, illegal_insn, fault_l, mal_l,
    input logic                  fault_s, mal_s, breakpoint, env_m, ret, pipe_clear, ren, wen,
    input logic                  timer_int, soft_int, ext_int,
    input logic                  timer_int_clear, soft_int_clear, ext_int_clear,
    input logic                  invalid_csr, insert_pc, intr
);

    int unsigned           err_count = 0;
    logic [`PRIV_XLEN-1:0] sh_mtvec, sh_mepc, sh_mcause, sh_minstret;
    logic [`PRIV_XLEN-1:0] sh_mscratch, sh_mtval, sh_mie;
    logic                  sh_mstatus_mie, sh_mpie;
    logic [`PRIV_XLEN-1:0] old_val, new_val, exp_pc, base;
    logic                  i_f, d_ok, exc, exp_intr, trap, known, impl, sw_wr;
    logic [2:0]            pend, en;
    logic [30:0]           cause, ex_code, int_code;

    always_comb begin
        i_f  = !(iaddr >= `PMA_MEM_BASE && iaddr <= `PMA_MEM_TOP);
        d_ok = (daddr >= `PMA_MEM_BASE && daddr <= `PMA_MEM_TOP)
            || (daddr >= `PMA_IO_BASE && daddr <= `PMA_IO_TOP);
        exc  = fault_insn | i_f | mal_insn | illegal_insn | breakpoint | env_m | mal_s
            | fault_s | (wen & !d_ok) | mal_l | fault_l | (ren & !d_ok);
        if (fault_insn || i_f) ex_code = 31'd1;
        else if (mal_insn) ex_code = 31'd0;
        else if (illegal_insn) ex_code = 31'd2;
        else if (breakpoint) ex_code = 31'd3;
        else if (env_m) ex_code = 31'd11;
        else if (mal_s) ex_code = 31'd6;
        else if (fault_s || (wen && !d_ok)) ex_code = 31'd7;
        else if (mal_l) ex_code = 31'd4;
        else ex_code = 31'd5;
        // Pending and enabled, order is ext, soft, timer
        en       = pend & {sh_mie[11], sh_mie[3], sh_mie[7]};
        int_code = en[2] ? 31'd11 : (en[1] ? 31'd3 : 31'd7);
        exp_intr = !exc && pipe_clear && sh_mstatus_mie && (en != 3'b000);
        cause    = exc ? ex_code : int_code;
        trap     = exc | exp_intr;
        base     = {sh_mtvec[31:2], 2'b00};
        if (ret && !trap) exp_pc = sh_mepc;
        else if (exp_intr && sh_mtvec[0]) exp_pc = base + {cause[29:0], 2'b00};
        else exp_pc = base;
        impl = 1'b1;
        case (csr_addr)
            12'h300: old_val = {19'd0, 2'b11, 3'd0, sh_mpie, 3'd0, sh_mstatus_mie, 3'd0};
            12'h304: old_val = sh_mie;
            12'h305: old_val = sh_mtvec;
            12'h340: old_val = sh_mscratch;
            12'h341: old_val = sh_mepc;
            12'h342: old_val = sh_mcause;
            12'h343: old_val = sh_mtval;
            12'h344: old_val = {20'd0, pend[2], 3'd0, pend[0], 3'd0, pend[1], 3'd0};
            12'hb02: old_val = sh_minstret;
            default: begin
                old_val = '0;
                impl    = 1'b0;
            end
        endcase
        // mepc, mscratch and mtval hold X until first written
        known   = impl && !$isunknown(old_val);
        new_val = swap ? wdata : (set ? (old_val | wdata) : (old_val & ~wdata));
        sw_wr   = valid_write & (swap | set | clr) & impl & !trap;
    end

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            sh_mtvec       <= `PRIV_MTVEC_RESET;
            sh_mcause      <= '0;
            sh_minstret    <= '0;
            sh_mie         <= '0;
            sh_mstatus_mie <= 1'b0;
            sh_mpie        <= 1'b0;
            pend           <= '0;
        end else begin
            pend <= (pend | {ext_int, soft_int, timer_int})
                  & ~{ext_int_clear, soft_int_clear, timer_int_clear};
            if (trap) begin
                sh_mepc   <= epc;
                sh_mcause <= {exp_intr, cause};
                sh_mtval  <= exp_intr ? '0 : badaddr;
            end else if (sw_wr) begin
                case (csr_addr)
                    12'h304: sh_mie <= new_val & 32'h0000_0888;
                    12'h305: sh_mtvec <= {new_val[31:2], 1'b0, new_val[0]};
                    12'h340: sh_mscratch <= new_val;
                    12'h341: sh_mepc <= new_val;
                    12'h342: sh_mcause <= new_val;
                    12'h343: sh_mtval <= new_val;
                    default: ;
                endcase
            end
            // Trap entry and mret beat a software write of mstatus
            if (trap) begin
                sh_mpie        <= sh_mstatus_mie;
                sh_mstatus_mie <= 1'b0;
            end else if (ret) begin
                sh_mstatus_mie <= sh_mpie;
                sh_mpie        <= 1'b1;
            end else if (sw_wr && csr_addr == 12'h300) begin
                sh_mstatus_mie <= new_val[3];
                sh_mpie        <= new_val[7];
            end
            if (sw_wr && csr_addr == 12'hb02) sh_minstret <= new_val;
            else if (wb_enable && instr) sh_minstret <= sh_minstret + 32'd1;
        end
    end

    a_rdata: assert property (@(posedge CLK) disable iff (!rst_n) known |-> rdata == old_val)
        else begin
            err_count++;
            $error("Error t=%0t rdata exp %h got %h", $time, $sampled(old_val), $sampled(rdata));
        end
    a_invalid: assert property (@(posedge CLK) disable iff (!rst_n) invalid_csr == !impl)
        else begin
            err_count++;
            $error("Error t=%0t invalid_csr exp %b got %b", $time, !$sampled(impl),
                   $sampled(invalid_csr));
        end
    a_insert: assert property (@(posedge CLK) disable iff (!rst_n) insert_pc == (trap | ret))
        else begin
            err_count++;
            $error("Error t=%0t insert_pc exp %b got %b", $time, $sampled(trap | ret),
                   $sampled(insert_pc));
        end
    a_pc: assert property (@(posedge CLK) disable iff (!rst_n) insert_pc |-> priv_pc == exp_pc)
        else begin
            err_count++;
            $error("Error t=%0t priv_pc exp %h got %h", $time, $sampled(exp_pc),
                   $sampled(priv_pc));
        end
    a_intr: assert property (@(posedge CLK) disable iff (!rst_n) intr == exp_intr)
        else begin
            err_count++;
            $error("Error t=%0t intr exp %b got %b", $time, $sampled(exp_intr),
                   $sampled(intr));
        end

endmodule

bind priv_block priv_asserts i_priv_asserts (.*);

`default_nettype wire

/* verification/tb_priv.sv */
// Inputs change 2 ns after each rising edge; results are checked by the bound assertions
`timescale 1ns/100ps
`include "priv_defines.svh"
`default_nettype none

module tb_priv;

    logic        CLK, rst_n, swap, set, clr, valid_write, wb_enable, instr;
    logic        fault_insn, mal_insn, illegal_insn, fault_l, mal_l, fault_s, mal_s;
    logic        breakpoint, env_m, ret, pipe_clear, ren, wen, invalid_csr, insert_pc, intr;
    logic        timer_int, soft_int, ext_int, timer_int_clear, soft_int_clear, ext_int_clear;
    logic [11:0] csr_addr;
    logic [31:0] wdata, epc, badaddr, iaddr, daddr, rdata, priv_pc, r;
    int          cycles = 0;
    int          seed = 32'hd167_dd2b;

    priv_block i_priv_block (.*);

    initial begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    always @(posedge CLK) cycles++;

    always @(negedge CLK) begin
        if (i_priv_block.i_priv_asserts.err_count != 0) begin
            $display("Checks failed");
            $fatal(1, "an assertion failed");
        end else if (cycles >= 400) begin
            $display("Checks failed");
            $fatal(1, "timeout after %0d cycles", cycles);
        end
    end

    task automatic step();
        @(posedge CLK);
        #2;
    endtask

    // One access cycle, then one read cycle at the same address
    task automatic csr_access(input logic [11:0] a, input logic [2:0] op, input logic [31:0] d);
        csr_addr    = a;
        {swap, set, clr} = op;
        valid_write = |op;
        wdata       = d;
        step();
        {swap, set, clr} = 3'b000;
        valid_write = 1'b0;
        step();
    endtask

    initial begin
        {swap, set, clr, valid_write, wb_enable, instr, fault_insn, mal_insn} = '0;
        {illegal_insn, fault_l, mal_l, fault_s, mal_s, breakpoint, env_m, ret} = '0;
        {pipe_clear, ren, wen, timer_int, soft_int, ext_int} = '0;
        {timer_int_clear, soft_int_clear, ext_int_clear} = '0;
        csr_addr = 12'h305;
        {wdata, epc, badaddr, daddr} = '0;
        iaddr = 32'h0000_1000;
        rst_n = 1'b0;
        repeat (4) @(posedge CLK);
        #2;
        rst_n = 1'b1;
        csr_access(12'h305, 3'b100, $random(seed));
        csr_access(12'h305, 3'b010, $random(seed));
        csr_access(12'h305, 3'b001, $random(seed));
        csr_access(12'h340, 3'b100, $random(seed));
        csr_access(12'h340, 3'b010, $random(seed));
        csr_access(12'h340, 3'b001, $random(seed));
        csr_access(12'h7c0, 3'b000, 32'h0);
        csr_access(12'h305, 3'b100, 32'h0000_0200);
        // Several exceptions at once, illegal ranks highest
        illegal_insn = 1'b1;
        env_m        = 1'b1;
        mal_l        = 1'b1;
        epc          = $random(seed);
        badaddr      = $random(seed);
        step();
        {illegal_insn, env_m, mal_l} = 3'b000;
        csr_access(12'h342, 3'b000, 32'h0);
        csr_access(12'h341, 3'b000, 32'h0);
        csr_access(12'h343, 3'b000, 32'h0);
        ren   = 1'b1;
        daddr = 32'h4000_0000;
        step();
        ren   = 1'b0;
        daddr = 32'h0;
        csr_access(12'h342, 3'b000, 32'h0);
        iaddr = 32'h8000_0010;
        step();
        iaddr = 32'h0000_1000;
        csr_access(12'h342, 3'b000, 32'h0);
        // Vectored mode with all machine interrupts enabled
        csr_access(12'h305, 3'b100, 32'h0000_0201);
        csr_access(12'h304, 3'b100, 32'h0000_0888);
        csr_access(12'h300, 3'b010, 32'h0000_0008);
        ext_int   = 1'b1;
        timer_int = 1'b1;
        step();
        {ext_int, timer_int} = 2'b00;
        repeat (2) step();
        pipe_clear = 1'b1;
        step();
        {ext_int_clear, timer_int_clear} = 2'b11;
        soft_int = 1'b1;
        repeat (2) step();
        {ext_int_clear, timer_int_clear, soft_int} = 3'b000;
        soft_int_clear = 1'b1;
        pipe_clear     = 1'b0;
        step();
        soft_int_clear = 1'b0;
        ret = 1'b1;
        step();
        ret = 1'b0;
        csr_access(12'h300, 3'b000, 32'h0);
        repeat (20) begin
            r = $random(seed);
            wb_enable = r[0];
            instr     = r[1];
            step();
        end
        {wb_enable, instr} = 2'b00;
        csr_access(12'hb02, 3'b000, 32'h0);
        step();
        if (i_priv_block.i_priv_asserts.err_count != 0) begin
            $display("Checks failed");
            $fatal(1, "an assertion failed");
        end else begin
            $display("All checks passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* tb.f */
+incdir+hdl
hdl/priv_pkg.sv
hdl/priv_csr.sv
hdl/priv_trap_handler.sv
hdl/priv_pipe_control.sv
hdl/priv_pma.sv
hdl/priv_block.sv
verification/priv_asserts.sv
verification/tb_priv.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_priv
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timing
RUNFLAGS  ?= +verilator+error+limit+100

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f tb.f

run: compile
	-./$(OBJ_DIR)/V$(TOP) $(RUNFLAGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "All checks passed" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
